/* vlog.f */
verilog/vec_pkg.sv
verilog/vec_vrf.sv
verilog/vec_lane.sv
verilog/vec_reduce.sv
verilog/vec_sequencer.sv
verilog/vec_dispatcher.sv
verilog/vec_top.sv
testbench/tb_clock_gen.sv
testbench/tb_vec_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module tb_vec_top \
  -Mdir obj_dir

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/Vtb_vec_top

/* testbench/tb_vec_top.sv */
// Testbench for vec_top with stimulus, register-file model, reference function and checks

`timescale 1ns/1ps

module tb_vec_top;

  import vec_pkg::*;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 8;
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane;
  localparam int unsigned NrRandom     = 40;
  localparam int unsigned ReqTimeout   = 200;
  localparam int unsigned DrainTimeout = 2000;
  localparam int unsigned ResetTimeout = 50;

  // Expected response plus whether its result field is meaningful
  typedef struct packed {
    logic      check_result;
    vec_resp_t resp;
  } exp_t;

  logic      clk;
  logic      reset;
  vec_req_t  req;
  logic      req_valid;
  logic      req_ready;
  vec_resp_t resp;
  logic      resp_valid;

  // Flat element view of every register in the register file
  elem_t       model_q [NrVRegs][VlMax] = '{default: '0};
  exp_t        exp_q[$];
  int unsigned sent_count = 0;
  int unsigned resp_count = 0;
  logic [31:0] lfsr_q     = 32'd66;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk  ),
    .reset_o(reset)
  );

  vec_top #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) u_dut (
    .clk_i       (clk       ),
    .reset_i     (reset     ),
    .req_i       (req       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .resp_o      (resp      ),
    .resp_valid_o(resp_valid)
  );

  ////////////////////
  // Error handling
  ////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
      abort_run("Response does not match the reference");
    end
  endtask

  ////////////////////
  // Random numbers
  ////////////////////

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(input int unsigned nbits, output logic [31:0] value);
    value = '0;
    for (int unsigned b = 0; b < nbits; b++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic is_legal(input vec_req_t r);
    return (int'(r.op) < 5) && (int'(r.vl) <= int'(VlMax));
  endfunction

  // Expected response from the model as it stands before the instruction
  function automatic exp_t ref_response(input vec_req_t r);
    exp_t  e;
    elem_t sum;
    e = '0;
    if (!is_legal(r)) begin
      e.check_result = 1'b1;
      e.resp.illegal = 1'b1;
    end else if (r.op == VOP_REDSUM) begin
      sum = r.scalar;
      for (int i = 0; i < int'(r.vl); i++) begin
        sum = sum + model_q[r.vs2][i];
      end
      e.check_result = 1'b1;
      e.resp.result  = sum;
    end
    return e;
  endfunction

  // Only elements below vl change and each reads the same element of its sources
  function automatic void apply_to_model(input vec_req_t r);
    if (!is_legal(r) || r.op == VOP_REDSUM) begin
      return;
    end
    for (int i = 0; i < int'(r.vl); i++) begin
      case (r.op)
        VOP_ADD_VV: model_q[r.vd][i] = model_q[r.vs1][i] + model_q[r.vs2][i];
        VOP_XOR_VV: model_q[r.vd][i] = model_q[r.vs1][i] ^ model_q[r.vs2][i];
        VOP_ADD_VX: model_q[r.vd][i] = model_q[r.vs2][i] + r.scalar;
        default:    model_q[r.vd][i] = r.scalar;
      endcase
    end
  endfunction

  ////////////////////
  // Request driving
  ////////////////////

  function automatic vec_req_t make_req(input logic [2:0] op_code, input int vd, input int vs1,
                                        input int vs2, input elem_t scalar, input int vl);
    vec_req_t r;
    r.op     = vec_op_e'(op_code);
    r.vd     = vreg_t'(vd);
    r.vs1    = vreg_t'(vs1);
    r.vs2    = vreg_t'(vs2);
    r.scalar = scalar;
    r.vl     = vlen_t'(vl);
    return r;
  endfunction

  // Called on a rising edge and returns on the edge of the transfer
  task automatic send_req(input vec_req_t r);
    int unsigned waited;
    req       <= r;
    req_valid <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > ReqTimeout) begin
        abort_run("Timed out waiting for req_ready_o");
      end
      @(negedge clk);
    end
    exp_q.push_back(ref_response(r));
    apply_to_model(r);
    sent_count++;
    @(posedge clk);
  endtask

  task automatic wait_for_responses();
    int unsigned waited;
    waited = 0;
    while (resp_count != sent_count) begin
      waited++;
      if (waited > DrainTimeout) begin
        abort_run("Timed out waiting for outstanding responses");
      end
      @(posedge clk);
    end
  endtask

  ////////////////////
  // Response checking
  ////////////////////

  initial begin : compare_responses
    exp_t e;
    forever begin
      @(negedge clk);
      if (!reset && resp_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("A response arrived with no request outstanding");
        end
        e = exp_q.pop_front();
        check_value("resp_o.illegal", {31'b0, resp.illegal}, {31'b0, e.resp.illegal});
        if (e.check_result) begin
          check_value("resp_o.result", resp.result, e.resp.result);
        end
        resp_count++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    int unsigned waited;
    logic [31:0] op_bits;
    logic [31:0] vd_bits;
    logic [31:0] vs1_bits;
    logic [31:0] vs2_bits;
    logic [31:0] scalar_bits;
    logic [31:0] mode_bits;
    logic [31:0] vl_bits;
    int          vl;

    req       = '0;
    req_valid = 1'b0;

    // Handshake outputs stay low while reset is held
    waited = 0;
    @(negedge clk);
    while (reset) begin
      check_value("req_ready_o", {31'b0, req_ready}, 32'h0);
      check_value("resp_valid_o", {31'b0, resp_valid}, 32'h0);
      waited++;
      if (waited > ResetTimeout) begin
        abort_run("Reset was never released");
      end
      @(negedge clk);
    end
    @(posedge clk);

    // Splat then reduce at full length and at a length off the lane grid
    send_req(make_req(VOP_MV_VX, 1, 0, 0, 32'h0000_0011, VlMax));
    send_req(make_req(VOP_REDSUM, 0, 0, 1, 32'h0000_0005, VlMax));
    send_req(make_req(VOP_MV_VX, 2, 0, 0, 32'h0000_0007, 13));
    send_req(make_req(VOP_REDSUM, 0, 0, 2, 32'h0000_0003, 13));

    // Element-wise ops with wraparound
    send_req(make_req(VOP_MV_VX, 3, 0, 0, 32'hFFFF_FFF0, VlMax));
    send_req(make_req(VOP_MV_VX, 4, 0, 0, 32'h0000_0025, VlMax));
    send_req(make_req(VOP_ADD_VV, 5, 3, 4, 32'h0, VlMax));
    send_req(make_req(VOP_REDSUM, 0, 0, 5, 32'h0, VlMax));
    send_req(make_req(VOP_XOR_VV, 6, 3, 4, 32'h0, 21));
    send_req(make_req(VOP_REDSUM, 0, 0, 6, 32'h1234_5678, VlMax));
    send_req(make_req(VOP_ADD_VX, 7, 0, 4, 32'hFFFF_FFFF, VlMax));
    send_req(make_req(VOP_REDSUM, 0, 0, 7, 32'hFFFF_FFFF, VlMax));

    // Short vl leaves the tail alone and vl of 0 returns the scalar
    send_req(make_req(VOP_MV_VX, 8, 0, 0, 32'h0000_0100, VlMax));
    send_req(make_req(VOP_MV_VX, 8, 0, 0, 32'h0000_0003, 6));
    send_req(make_req(VOP_REDSUM, 0, 0, 8, 32'h0, VlMax));
    send_req(make_req(VOP_MV_VX, 9, 0, 0, 32'hDEAD_BEEF, 0));
    send_req(make_req(VOP_REDSUM, 0, 0, 9, 32'h0, VlMax));
    send_req(make_req(VOP_REDSUM, 0, 0, 8, 32'h0000_ABCD, 0));

    // Unassigned op and oversized vl followed by a reduction of the untouched v8
    send_req(make_req(3'd6, 8, 0, 0, 32'h5555_5555, VlMax));
    send_req(make_req(VOP_MV_VX, 8, 0, 0, 32'h7777_7777, VlMax + 8));
    send_req(make_req(VOP_REDSUM, 0, 0, 8, 32'h0000_0001, VlMax));

    req_valid <= 1'b0;
    wait_for_responses();
    @(posedge clk);

    // Random legal and illegal instructions with req_valid_i held high
    for (int k = 0; k < int'(NrRandom); k++) begin
      take_bits(3, op_bits);
      take_bits(3, vd_bits);
      take_bits(3, vs1_bits);
      take_bits(3, vs2_bits);
      take_bits(32, scalar_bits);
      take_bits(3, mode_bits);
      if (mode_bits == 0) begin
        take_bits(5, vl_bits);
        vl = int'(VlMax) + 1 + int'(vl_bits);
      end else begin
        take_bits(6, vl_bits);
        vl = int'(vl_bits) % (int'(VlMax) + 1);
      end
      send_req(make_req(op_bits[2:0], int'(vd_bits), int'(vs1_bits), int'(vs2_bits),
                        scalar_bits, vl));
    end

    req_valid <= 1'b0;
    wait_for_responses();
    // Idle cycles so a stray response still reaches the comparison
    repeat (5) @(posedge clk);

    $display("Everything OK");
    $finish;
  end

endmodule : tb_vec_top

/* testbench/tb_clock_gen.sv */
// Clock and reset generator for the vector coprocessor testbench

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned HalfPeriodNs = 10,
  parameter int unsigned ResetCycles  = 5
) (
  output logic clk_o,
  output logic reset_o
);

  // 20 ns period with the default half period
  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : tb_clock_gen

/* verilog/vec_top.sv */
// Top level of the vector coprocessor with dispatcher, sequencer, lanes and reducer

`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vec_pkg::vec_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output vec_pkg::vec_resp_t resp_o,
  output logic               resp_valid_o
);

  import vec_pkg::*;

  localparam int unsigned VlMax = NrLanes * ElemsPerLane;

  // Dispatcher to sequencer
  vec_req_t seq_req;
  logic     seq_req_valid;
  logic     seq_req_ready;
  logic     seq_done_valid;
  elem_t    seq_result;

  // Sequencer to lanes and reducer
  vec_req_t pe_req;
  logic     pe_req_valid;
  logic     red_valid;
  elem_t    red_result;

  logic  [NrLanes-1:0] lane_done;
  elem_t [NrLanes-1:0] lane_partial;

  //////////////////////
  // Control
  //////////////////////

  vec_dispatcher #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_dispatcher (
    .clk_i           (clk_i         ),
    .reset_i         (reset_i       ),
    .req_i           (req_i         ),
    .req_valid_i     (req_valid_i   ),
    .req_ready_o     (req_ready_o   ),
    .resp_o          (resp_o        ),
    .resp_valid_o    (resp_valid_o  ),
    .seq_req_o       (seq_req       ),
    .seq_req_valid_o (seq_req_valid ),
    .seq_req_ready_i (seq_req_ready ),
    .seq_done_valid_i(seq_done_valid),
    .seq_result_i    (seq_result    )
  );

  vec_sequencer i_sequencer (
    .clk_i           (clk_i         ),
    .reset_i         (reset_i       ),
    .seq_req_i       (seq_req       ),
    .seq_req_valid_i (seq_req_valid ),
    .seq_req_ready_o (seq_req_ready ),
    .seq_done_valid_o(seq_done_valid),
    .seq_result_o    (seq_result    ),
    .pe_req_o        (pe_req        ),
    .pe_req_valid_o  (pe_req_valid  ),
    .red_valid_i     (red_valid     ),
    .red_result_i    (red_result    )
  );

  //////////////////////
  // Datapath
  //////////////////////

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .LaneId      (lane        )
    ) i_lane (
      .clk_i         (clk_i             ),
      .reset_i       (reset_i           ),
      .pe_req_i      (pe_req            ),
      .pe_req_valid_i(pe_req_valid      ),
      .lane_done_o   (lane_done[lane]   ),
      .lane_partial_o(lane_partial[lane])
    );
  end : gen_lanes

  vec_reduce #(
    .NrLanes(NrLanes)
  ) i_reduce (
    .clk_i         (clk_i        ),
    .reset_i       (reset_i      ),
    .start_i       (pe_req_valid ),
    .scalar_i      (pe_req.scalar),
    .lane_done_i   (lane_done    ),
    .lane_partial_i(lane_partial ),
    .red_valid_o   (red_valid    ),
    .red_result_o  (red_result   )
  );

  // Elaboration checks
  if (NrLanes == 0 || (NrLanes & (NrLanes - 1)) != 0)
    $error("NrLanes must be a nonzero power of two");

  if (VlMax > 64)
    $error("NrLanes * ElemsPerLane must not exceed 64");

endmodule : vec_top

/* verilog/vec_dispatcher.sv */
// Request slot, legality check and response path of the vector dispatcher

`timescale 1ns/1ps

module vec_dispatcher #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Core side
  input  vec_pkg::vec_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output vec_pkg::vec_resp_t resp_o,
  output logic               resp_valid_o,
  // Sequencer side
  output vec_pkg::vec_req_t  seq_req_o,
  output logic               seq_req_valid_o,
  input  logic               seq_req_ready_i,
  input  logic               seq_done_valid_i,
  input  vec_pkg::elem_t     seq_result_i
);

  import vec_pkg::*;

  localparam int unsigned VlMax = NrLanes * ElemsPerLane;

  vec_req_t slot_q;
  logic     slot_valid_q;
  logic     slot_legal;
  logic     busy_q;
  logic     ill_resp_q;
  logic     req_fire;
  logic     seq_fire;
  logic     ill_fire;

  //////////////////////
  // Legality check
  //////////////////////

  assign slot_legal = (slot_q.op <= VOP_REDSUM) && (slot_q.vl <= VlMax);

  // No requests taken while in reset
  assign req_ready_o = ~slot_valid_q & ~reset_i;
  assign req_fire    = req_valid_i & req_ready_o;

  assign seq_req_o       = slot_q;
  assign seq_req_valid_o = slot_valid_q & slot_legal;
  assign seq_fire        = seq_req_valid_o & seq_req_ready_i;

  // Illegal ones wait until the older instruction has retired
  assign ill_fire = slot_valid_q & ~slot_legal & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= 1'b0;
      busy_q       <= 1'b0;
      ill_resp_q   <= 1'b0;
    end else begin
      ill_resp_q <= ill_fire;
      if (req_fire) begin
        slot_valid_q <= 1'b1;
      end else if (seq_fire || ill_fire) begin
        slot_valid_q <= 1'b0;
      end
      // A new issue may overlap the completion pulse of the previous one
      if (seq_fire) begin
        busy_q <= 1'b1;
      end else if (seq_done_valid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      slot_q <= req_i;
    end
  end

  //////////////////////
  // Response forming
  //////////////////////

  // Completion and illegal pulses never coincide
  assign resp_valid_o   = seq_done_valid_i | ill_resp_q;
  assign resp_o.result  = seq_done_valid_i ? seq_result_i : '0;
  assign resp_o.illegal = ill_resp_q;

  // Back-to-back responses only come from a sequencer completion
  a_resp_spacing: assert property (
    @(posedge clk_i) disable iff (reset_i)
    resp_valid_o |=> (!resp_valid_o || seq_done_valid_i)
  ) else $error("Two responses in a row without a sequencer completion");

endmodule : vec_dispatcher

/* verilog/vec_sequencer.sv */
// Single-instruction sequencer issuing to the lanes and waiting for the reducer

`timescale 1ns/1ps

module vec_sequencer (
  input  logic              clk_i,
  input  logic              reset_i,
  // Dispatcher side
  input  vec_pkg::vec_req_t seq_req_i,
  input  logic              seq_req_valid_i,
  output logic              seq_req_ready_o,
  output logic              seq_done_valid_o,
  output vec_pkg::elem_t    seq_result_o,
  // Lane broadcast
  output vec_pkg::vec_req_t pe_req_o,
  output logic              pe_req_valid_o,
  // Reducer completion
  input  logic              red_valid_i,
  input  vec_pkg::elem_t    red_result_i
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } seq_state_e;

  seq_state_e state_q, state_d;
  vec_req_t   insn_q;
  elem_t      result_q;
  logic       done_q;

  assign seq_req_ready_o  = (state_q == IDLE);
  assign pe_req_valid_o   = (state_q == ISSUE);
  assign pe_req_o         = insn_q;
  assign seq_done_valid_o = done_q;
  assign seq_result_o     = result_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (seq_req_valid_i) state_d = ISSUE;
      ISSUE: state_d = WAIT;
      WAIT:  if (red_valid_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Done goes out the cycle after the reducer answers
      done_q  <= (state_q == WAIT) && red_valid_i;
    end
  end

  // Instruction and result registers
  always_ff @(posedge clk_i) begin
    if (seq_req_valid_i && seq_req_ready_o) begin
      insn_q <= seq_req_i;
    end
    if (red_valid_i) begin
      result_q <= red_result_i;
    end
  end

  a_no_red_in_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    red_valid_i |-> (state_q != IDLE)
  ) else $error("Reducer completion without an instruction in flight");

endmodule : vec_sequencer

/* verilog/vec_reduce.sv */
// Reduction unit folding lane partial sums and the scalar into one result

`timescale 1ns/1ps

module vec_reduce #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             start_i,
  input  vec_pkg::elem_t                   scalar_i,
  input  logic           [NrLanes-1:0]     lane_done_i,
  input  vec_pkg::elem_t [NrLanes-1:0]     lane_partial_i,
  output logic                             red_valid_o,
  output vec_pkg::elem_t                   red_result_o
);

  import vec_pkg::*;

  logic  [NrLanes-1:0] got_q;
  logic                pending_q;
  logic                valid_q;
  logic                all_in;
  elem_t [NrLanes-1:0] part_q;

  // Lanes finish at different times
  assign all_in = &(got_q | lane_done_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      got_q     <= '0;
      pending_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= pending_q && all_in;
      if (start_i) begin
        got_q     <= '0;
        pending_q <= 1'b1;
      end else begin
        got_q <= got_q | lane_done_i;
        if (pending_q && all_in) begin
          pending_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int l = 0; l < NrLanes; l++) begin
      if (lane_done_i[l]) begin
        part_q[l] <= lane_partial_i[l];
      end
    end
  end

  // Sum wraps modulo 2^32
  always_comb begin
    red_result_o = scalar_i;
    for (int l = 0; l < NrLanes; l++) begin
      red_result_o = red_result_o + part_q[l];
    end
  end

  assign red_valid_o = valid_q;

endmodule : vec_reduce

/* verilog/vec_lane.sv */
// One vector lane with element loop, integer ALU and partial sum of vs2

`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 8,
  parameter int unsigned LaneId       = 0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  vec_pkg::vec_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              lane_done_o,
  output vec_pkg::elem_t    lane_partial_o
);

  import vec_pkg::*;

  localparam int unsigned SlotWidth = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  vec_req_t             insn_q;
  vlen_t                full_rounds;
  vlen_t                rem_elems;
  vlen_t                elem_cnt;
  vlen_t                elem_cnt_q;
  logic [SlotWidth-1:0] slot_q;
  logic                 busy_q;
  logic                 done_q;
  logic                 last_elem;
  logic                 wr_en;
  elem_t                rd_a_data;
  elem_t                rd_b_data;
  elem_t                alu_res;
  elem_t                acc_q;

  // Element i sits in lane i mod NrLanes, slot i / NrLanes
  assign full_rounds = vlen_t'(pe_req_i.vl / NrLanes);
  assign rem_elems   = vlen_t'(pe_req_i.vl % NrLanes);
  assign elem_cnt    = full_rounds + vlen_t'(rem_elems > LaneId);

  assign last_elem = (vlen_t'(slot_q) == elem_cnt_q - vlen_t'(1));
  assign wr_en     = busy_q && (insn_q.op != VOP_REDSUM);

  vec_vrf #(
    .ElemsPerLane(ElemsPerLane)
  ) i_vrf (
    .clk_i      (clk_i     ),
    .rd_a_reg_i (insn_q.vs1),
    .rd_b_reg_i (insn_q.vs2),
    .rd_slot_i  (slot_q    ),
    .rd_a_data_o(rd_a_data ),
    .rd_b_data_o(rd_b_data ),
    .wr_en_i    (wr_en     ),
    .wr_reg_i   (insn_q.vd ),
    .wr_slot_i  (slot_q    ),
    .wr_data_i  (alu_res   )
  );

  //////////////////////
  // ALU
  //////////////////////

  always_comb begin
    case (insn_q.op)
      VOP_ADD_VV: alu_res = rd_a_data + rd_b_data;
      VOP_XOR_VV: alu_res = rd_a_data ^ rd_b_data;
      VOP_ADD_VX: alu_res = rd_b_data + insn_q.scalar;
      VOP_MV_VX:  alu_res = insn_q.scalar;
      default:    alu_res = rd_b_data;
    endcase
  end

  //////////////////////
  // Element loop
  //////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      slot_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (pe_req_valid_i) begin
        slot_q <= '0;
        busy_q <= (elem_cnt != '0);
        // Empty lane reports right away
        done_q <= (elem_cnt == '0);
      end else if (busy_q) begin
        slot_q <= slot_q + 1'b1;
        if (last_elem) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      insn_q     <= pe_req_i;
      elem_cnt_q <= elem_cnt;
      acc_q      <= '0;
    end else if (busy_q) begin
      acc_q <= acc_q + rd_b_data;
    end
  end

  assign lane_done_o    = done_q;
  assign lane_partial_o = acc_q;

  a_no_issue_while_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    pe_req_valid_i |-> !busy_q
  ) else $error("Lane %0d got a new instruction while busy", LaneId);

endmodule : vec_lane

/* verilog/vec_vrf.sv */
// Register-file slice of one lane, two combinational reads and one clocked write

`timescale 1ns/1ps

module vec_vrf #(
  parameter  int unsigned ElemsPerLane = 8,
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                 clk_i,
  input  vec_pkg::vreg_t       rd_a_reg_i,
  input  vec_pkg::vreg_t       rd_b_reg_i,
  input  logic [SlotWidth-1:0] rd_slot_i,
  output vec_pkg::elem_t       rd_a_data_o,
  output vec_pkg::elem_t       rd_b_data_o,
  input  logic                 wr_en_i,
  input  vec_pkg::vreg_t       wr_reg_i,
  input  logic [SlotWidth-1:0] wr_slot_i,
  input  vec_pkg::elem_t       wr_data_i
);

  import vec_pkg::*;

  // Register by slot, cleared only at simulation start
  elem_t vrf_q [NrVRegs][ElemsPerLane] = '{default: '0};

  assign rd_a_data_o = vrf_q[rd_a_reg_i][rd_slot_i];
  assign rd_b_data_o = vrf_q[rd_b_reg_i][rd_slot_i];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      vrf_q[wr_reg_i][wr_slot_i] <= wr_data_i;
    end
  end

endmodule : vec_vrf

/* verilog/vec_pkg.sv */
// Shared widths, operation codes and request/response structs of the vector coprocessor

package vec_pkg;

  //////////////////////
  // Widths
  //////////////////////

  // One vector element or scalar operand
  localparam int unsigned ElemWidth = 32;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;

  // Vector length field, up to 64 elements
  localparam int unsigned VlWidth = 7;

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [4:0]           vreg_t;
  typedef logic [VlWidth-1:0]   vlen_t;

  //////////////////////
  // Operations
  //////////////////////

  // Codes 5 to 7 are left unassigned and rejected by the dispatcher
  typedef enum logic [2:0] {
    VOP_ADD_VV = 3'd0,
    VOP_XOR_VV = 3'd1,
    VOP_ADD_VX = 3'd2,
    VOP_MV_VX  = 3'd3,
    VOP_REDSUM = 3'd4
  } vec_op_e;

  //////////////////////
  // Request/response
  //////////////////////

  // One instruction as issued by the core side
  typedef struct packed {
    vec_op_e op;
    // Destination register
    vreg_t   vd;
    // Source registers
    vreg_t   vs1;
    vreg_t   vs2;
    // Scalar operand, also the reduction start value
    elem_t   scalar;
    // Number of active elements
    vlen_t   vl;
  } vec_req_t;

  // Response returned once per accepted request
  typedef struct packed {
    elem_t result;
    logic  illegal;
  } vec_resp_t;

endpackage : vec_pkg
